// File: rtl/gauss_score_pkg.sv
package gauss_score_pkg;

  // lane count limit, sets the headroom of the score
  localparam int MAX_FEATURES = 64;                  // upper bound on N_FEATURES

  localparam int FEAT_W  = 16;                       // feature and mean, two's complement
  localparam int PREC_W  = 16;                       // precision, unsigned
  localparam int DIFF_W  = FEAT_W + 1;               // feature - mean never wraps
  localparam int TERM_W  = 2 * DIFF_W + PREC_W;      // prec * diff^2, 50 bits
  localparam int SCORE_W = TERM_W + $clog2(MAX_FEATURES); // sum of up to 64 terms

  localparam int LANE_LATENCY = 2;                   // diff stage + weighted square stage

  typedef logic signed [FEAT_W-1:0]  feat_t;         // feature / mean sample
  typedef logic        [PREC_W-1:0]  prec_t;         // inverse variance weight
  typedef logic signed [DIFF_W-1:0]  diff_t;         // lane difference
  typedef logic        [TERM_W-1:0]  term_t;         // one lane contribution
  typedef logic        [SCORE_W-1:0] score_t;        // tree node and final score

endpackage

// File: rtl/feature_capture.sv
module feature_capture #(
  parameter int N_FEATURES = 8                                // lanes per vector
) (
  input  logic                   aclk,
  input  logic                   rst_n,
  input  logic                   in_valid,                    // one-cycle vector strobe
  input  gauss_score_pkg::feat_t feature [N_FEATURES],
  input  gauss_score_pkg::feat_t mean    [N_FEATURES],
  input  gauss_score_pkg::prec_t prec    [N_FEATURES],
  output logic                   cap_valid,                   // in_valid one cycle later
  output gauss_score_pkg::feat_t cap_feature [N_FEATURES],
  output gauss_score_pkg::feat_t cap_mean    [N_FEATURES],
  output gauss_score_pkg::prec_t cap_prec    [N_FEATURES]
);

  // strobe delay, keeps pace with the vector register below
  always_ff @(posedge aclk or negedge rst_n) begin
    if (!rst_n) begin
      cap_valid <= 1'b0;
    end else begin
      cap_valid <= in_valid;                                  // pulse follows data
    end
  end

  // vector register, loads only on a strobe
  always_ff @(posedge aclk or negedge rst_n) begin
    if (!rst_n) begin
      cap_feature <= '{default: '0};
      cap_mean    <= '{default: '0};
      cap_prec    <= '{default: '0};
    end else if (in_valid) begin                              // idle cycles hold last vector
      cap_feature <= feature;
      cap_mean    <= mean;
      cap_prec    <= prec;
    end
  end

endmodule

// File: rtl/score_lane.sv
module score_lane (
  input  logic                   aclk,
  input  logic                   rst_n,
  input  logic                   in_valid,                    // element strobe
  input  gauss_score_pkg::feat_t feature,
  input  gauss_score_pkg::feat_t mean,
  input  gauss_score_pkg::prec_t prec,
  output logic                   term_valid,                  // in_valid + LANE_LATENCY
  output gauss_score_pkg::term_t term                         // prec * (feature - mean)^2
);

  localparam int LAT    = gauss_score_pkg::LANE_LATENCY;      // 2 stages
  localparam int DIFF_W = gauss_score_pkg::DIFF_W;

  gauss_score_pkg::diff_t     diff_q;                         // stage 1 difference
  gauss_score_pkg::prec_t     prec_q;                         // stage 1 weight
  logic signed [2*DIFF_W-1:0] diff_sq;                        // always >= 0
  logic [LAT-1:0]             vld_q;                          // strobe shift register

  // strobe travels one bit per stage
  always_ff @(posedge aclk or negedge rst_n) begin
    if (!rst_n) begin
      vld_q <= '0;
    end else begin
      vld_q <= {vld_q[LAT-2:0], in_valid};
    end
  end

  // stage 1: widen both operands before subtracting
  always_ff @(posedge aclk or negedge rst_n) begin
    if (!rst_n) begin
      diff_q <= '0;
      prec_q <= '0;
    end else if (in_valid) begin
      diff_q <= gauss_score_pkg::diff_t'(feature)
              - gauss_score_pkg::diff_t'(mean);               // sign extended, exact
      prec_q <= prec;
    end
  end

  // signed square, 34 bits hold 65535^2
  assign diff_sq = diff_q * diff_q;

  // stage 2: weight by precision, result unsigned
  always_ff @(posedge aclk or negedge rst_n) begin
    if (!rst_n) begin
      term <= '0;
    end else if (vld_q[0]) begin                              // stage 1 holds fresh data
      term <= gauss_score_pkg::term_t'($unsigned(diff_sq))
            * gauss_score_pkg::term_t'(prec_q);               // fits TERM_W, no rounding
    end
  end

  assign term_valid = vld_q[LAT-1];

endmodule

// File: rtl/score_adder_tree.sv
module score_adder_tree #(
  parameter int N_FEATURES = 8                                // leaves of the tree
) (
  input  logic                    aclk,
  input  logic                    rst_n,
  input  logic                    in_valid,                   // strobe of the leaf terms
  input  gauss_score_pkg::term_t  terms [N_FEATURES],
  output logic                    score_valid,                // in_valid + LEVELS
  output gauss_score_pkg::score_t score
);

  localparam int LEVELS = $clog2(N_FEATURES);                 // 0 for a single lane

  // nodes on a level, odd counts round up
  function automatic int level_count(input int lvl);
    return (N_FEATURES + (1 << lvl) - 1) >> lvl;
  endfunction

  // index of a level's first node in the flat node array
  function automatic int level_base(input int lvl);
    int base;
    base = 0;
    for (int k = 0; k < lvl; k++) begin
      base += level_count(k);
    end
    return base;
  endfunction

  localparam int N_NODES = level_base(LEVELS + 1);            // all levels incl. leaves

  gauss_score_pkg::score_t node [N_NODES];                    // level 0 first, root last
  logic                    vld  [LEVELS+1];                   // vld[l] marks level l data

  // score width only covers MAX_FEATURES terms
  if (N_FEATURES < 1 || N_FEATURES > gauss_score_pkg::MAX_FEATURES) begin : g_range_err
    $error("score_adder_tree: N_FEATURES %0d out of range", N_FEATURES);
  end

  assign vld[0] = in_valid;

  // leaves, zero extended to score width
  for (genvar i = 0; i < N_FEATURES; i++) begin : g_leaf
    assign node[i] = gauss_score_pkg::score_t'(terms[i]);
  end

  for (genvar l = 0; l < LEVELS; l++) begin : g_level
    localparam int SRC_BASE = level_base(l);
    localparam int SRC_CNT  = level_count(l);
    localparam int DST_BASE = level_base(l + 1);

    // strobe delay, one flop per level
    always_ff @(posedge aclk or negedge rst_n) begin
      if (!rst_n) begin
        vld[l+1] <= 1'b0;
      end else begin
        vld[l+1] <= vld[l];
      end
    end

    for (genvar i = 0; i < level_count(l + 1); i++) begin : g_node
      if (2 * i + 1 < SRC_CNT) begin : g_add
        // neighbour pair
        always_ff @(posedge aclk or negedge rst_n) begin
          if (!rst_n) begin
            node[DST_BASE+i] <= '0;
          end else if (vld[l]) begin                          // load with its strobe
            node[DST_BASE+i] <= node[SRC_BASE+2*i] + node[SRC_BASE+2*i+1];
          end
        end
      end else begin : g_carry
        // unpaired last node, delayed so depth stays equal
        always_ff @(posedge aclk or negedge rst_n) begin
          if (!rst_n) begin
            node[DST_BASE+i] <= '0;
          end else if (vld[l]) begin
            node[DST_BASE+i] <= node[SRC_BASE+2*i];
          end
        end
      end
    end
  end

  // root is the only node on the last level
  assign score       = node[N_NODES-1];
  assign score_valid = vld[LEVELS];

endmodule

// File: rtl/gauss_score_top.sv
module gauss_score_top #(
  parameter int N_FEATURES = 8                                // lanes per vector
) (
  input  logic                    aclk,
  input  logic                    rst_n,
  input  logic                    in_valid,                   // one vector per strobe
  input  gauss_score_pkg::feat_t  feature [N_FEATURES],
  input  gauss_score_pkg::feat_t  mean    [N_FEATURES],
  input  gauss_score_pkg::prec_t  prec    [N_FEATURES],
  output logic                    score_valid,                // 3 + clog2(N) after strobe
  output gauss_score_pkg::score_t score
);

  logic                   cap_valid;                          // capture -> lanes
  gauss_score_pkg::feat_t cap_feature [N_FEATURES];
  gauss_score_pkg::feat_t cap_mean    [N_FEATURES];
  gauss_score_pkg::prec_t cap_prec    [N_FEATURES];
  gauss_score_pkg::term_t term        [N_FEATURES];           // lanes -> tree
  logic                   term_valid;                         // from lane 0

  feature_capture #(
    .N_FEATURES (N_FEATURES)
  ) u_capture (
    .aclk        (aclk),
    .rst_n       (rst_n),
    .in_valid    (in_valid),
    .feature     (feature),
    .mean        (mean),
    .prec        (prec),
    .cap_valid   (cap_valid),
    .cap_feature (cap_feature),
    .cap_mean    (cap_mean),
    .cap_prec    (cap_prec)
  );

  // all lanes run in lockstep, lane 0 speaks for the strobe
  for (genvar i = 0; i < N_FEATURES; i++) begin : g_lane
    if (i == 0) begin : g_first
      score_lane u_lane (
        .aclk       (aclk),
        .rst_n      (rst_n),
        .in_valid   (cap_valid),
        .feature    (cap_feature[i]),
        .mean       (cap_mean[i]),
        .prec       (cap_prec[i]),
        .term_valid (term_valid),
        .term       (term[i])
      );
    end else begin : g_rest
      score_lane u_lane (
        .aclk       (aclk),
        .rst_n      (rst_n),
        .in_valid   (cap_valid),
        .feature    (cap_feature[i]),
        .mean       (cap_mean[i]),
        .prec       (cap_prec[i]),
        .term_valid (),                                       // same as lane 0
        .term       (term[i])
      );
    end
  end

  score_adder_tree #(
    .N_FEATURES (N_FEATURES)
  ) u_tree (
    .aclk        (aclk),
    .rst_n       (rst_n),
    .in_valid    (term_valid),
    .terms       (term),
    .score_valid (score_valid),
    .score       (score)
  );

endmodule

// File: sim/gauss_score_asserts.sv
module gauss_score_asserts #(
  parameter int N_FEATURES = 8
) (
  input logic                    aclk,
  input logic                    rst_n,
  input logic                    in_valid,
  input logic                    score_valid,
  input gauss_score_pkg::score_t score
);
  timeunit 1ns;
  timeprecision 1ps;

  localparam int LATENCY = 3 + $clog2(N_FEATURES);        // 6 for 8 lanes

  int fill_cnt;                                           // edges since reset release

  always @(posedge aclk or negedge rst_n) begin
    if (!rst_n) begin
      fill_cnt <= 0;
    end else if (fill_cnt < LATENCY) begin
      fill_cnt <= fill_cnt + 1;
    end
  end

  a_quiet_in_reset: assert property (@(posedge aclk) !rst_n |-> !score_valid)
    else $error("score_valid high while in reset");

  // pipeline full, output strobe mirrors the input strobe
  a_fixed_latency: assert property (@(posedge aclk) disable iff (!rst_n)
    (fill_cnt == LATENCY) |-> (score_valid == $past(in_valid, LATENCY)))
    else $error("score_valid not in_valid delayed by %0d cycles", LATENCY);

  a_score_known: assert property (@(posedge aclk) score_valid |-> !$isunknown(score))
    else $error("score has unknown bits while valid");

endmodule

bind gauss_score_top gauss_score_asserts #(
  .N_FEATURES (N_FEATURES)
) u_asserts (
  .aclk        (aclk),
  .rst_n       (rst_n),
  .in_valid    (in_valid),
  .score_valid (score_valid),
  .score       (score)
);

// File: sim/gauss_score_tests.svh
`ifndef GAUSS_SCORE_TESTS_SVH
`define GAUSS_SCORE_TESTS_SVH

// outputs stay quiet through reset and one cycle past it
task automatic test_reset_state();
  repeat (RESET_CYCLES) begin
    @(negedge aclk);
    check_value("score_valid", 64'(score_valid), 64'd0);
    check_value("score", 64'(score), 64'd0);
  end
  rst_n = 1'b1;                                           // release after 10 edges
  @(negedge aclk);
  check_value("score_valid", 64'(score_valid), 64'd0);
  check_value("score", 64'(score), 64'd0);
endtask

task automatic test_known_vectors();
  @(negedge aclk);
  fill_random();
  mean = feature;                                         // zero diff everywhere
  mark_valid(64'd0);
  drain_results();

  @(negedge aclk);
  clear_vector();
  feature[3] = 16'sd10;                                   // diff 3
  mean[3]    = 16'sd7;
  prec[3]    = 16'd5;
  mark_valid(64'd45);                                     // 5 * 3 * 3
  drain_results();

  @(negedge aclk);
  for (int i = 0; i < N_FEATURES; i++) begin
    feature[i] = 16'h8000;                                // most negative
    mean[i]    = 16'h7fff;                                // most positive
    prec[i]    = 16'hffff;
  end
  // diff is -65535 in every lane
  mark_valid(64'(N_FEATURES) * 64'd65535 * 64'd65535 * 64'd65535);
  drain_results();
endtask

// isolated strobe seen valid only by the LATENCY-th edge after sampling
task automatic test_fixed_latency();
  idle_cycles(3);
  @(negedge aclk);
  fill_random();
  mark_valid(model_score());
  for (int k = 1; k <= LATENCY + 3; k++) begin
    @(negedge aclk);                                      // value edge k will sample
    in_valid = 1'b0;
    check_value("score_valid", 64'(score_valid), 64'(k == LATENCY));
  end
  drain_results();
endtask

task automatic test_streaming();
  result_cycles.delete();
  for (int i = 0; i < 50; i++) begin
    strobe_random();                                      // back to back
  end
  drain_results();
  check_value("result count", 64'(result_cycles.size()), 64'd50);
  check_value("result span", 64'(result_cycles[49] - result_cycles[0]), 64'd49);
endtask

task automatic test_gaps();
  result_cycles.delete();
  for (int i = 0; i < 100; i++) begin
    if (rand16() % 16'd3 == 16'd0) begin
      idle_cycles(1 + int'(rand16() % 16'd4));            // random hole in the stream
    end
    strobe_random();
  end
  drain_results();
  check_value("result count", 64'(result_cycles.size()), 64'd100);
endtask

`endif

// File: sim/gauss_score_tb.sv
module gauss_score_tb;
  timeunit 1ns;
  timeprecision 1ps;

  localparam int N_FEATURES   = 8;
  localparam int LATENCY      = 3 + $clog2(N_FEATURES);   // capture + 2 lane stages + tree
  localparam int RESET_CYCLES = 10;
  localparam int TEST_CYCLES  = 400;                      // rough length of all tests
  localparam int MAX_CYCLES   = 5 * TEST_CYCLES;          // generous margin
  localparam int DRAIN_LIMIT  = LATENCY + 10;             // wait bound for outstanding results

  logic                    aclk;
  logic                    rst_n;
  logic                    in_valid;
  gauss_score_pkg::feat_t  feature [N_FEATURES];
  gauss_score_pkg::feat_t  mean    [N_FEATURES];
  gauss_score_pkg::prec_t  prec    [N_FEATURES];
  logic                    score_valid;
  gauss_score_pkg::score_t score;

  logic [63:0] expected_q [$];                            // model scores in input order
  int          result_cycles [$];                         // cycle of each observed result
  logic [63:0] exp_score;                                 // popped by the monitor
  int          cycle_count = 0;
  logic [31:0] lcg_state   = 32'd2807;                    // random seed

  gauss_score_top #(
    .N_FEATURES (N_FEATURES)
  ) uut (
    .aclk        (aclk),
    .rst_n       (rst_n),
    .in_valid    (in_valid),
    .feature     (feature),
    .mean        (mean),
    .prec        (prec),
    .score_valid (score_valid),
    .score       (score)
  );

  always #5 aclk = ~aclk;                                 // 10 ns period

  // print the reason, then stop the run
  task automatic stop_failed(input string reason);
    $display("%s", reason);
    $display("test failed");
    $fatal(1, "run stopped at first error");
  endtask

  task automatic check_value(input string name, input logic [63:0] actual,
                             input logic [63:0] expected);
    if (actual !== expected) begin
      stop_failed($sformatf("MISMATCH at %0t: %s got %0d expected %0d",
                            $time, name, actual, expected));
    end
  endtask

  // 32-bit LCG, upper half is the better random part
  function automatic logic [15:0] rand16();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state[31:16];
  endfunction

  // sum of prec * (feature - mean)^2 in 64-bit signed math
  function automatic logic [63:0] model_score();
    longint acc;
    longint d;
    acc = 0;
    for (int i = 0; i < N_FEATURES; i++) begin
      d   = longint'(feature[i]) - longint'(mean[i]);   // sign extended
      acc += longint'(prec[i]) * d * d;                  // prec zero extended
    end
    return 64'(acc);
  endfunction

  task automatic clear_vector();
    feature = '{default: '0};
    mean    = '{default: '0};
    prec    = '{default: '0};
  endtask

  task automatic fill_random();
    for (int i = 0; i < N_FEATURES; i++) begin
      feature[i] = rand16();
      mean[i]    = rand16();
      prec[i]    = rand16();
    end
  endtask

  // strobe the vector already on the inputs
  task automatic mark_valid(input logic [63:0] expected);
    in_valid = 1'b1;
    expected_q.push_back(expected);
  endtask

  task automatic idle_cycles(input int n);
    repeat (n) begin
      @(negedge aclk);
      in_valid = 1'b0;
    end
  endtask

  task automatic strobe_random();
    @(negedge aclk);
    fill_random();
    mark_valid(model_score());
  endtask

  // wait for outstanding results, bounded
  task automatic drain_results();
    for (int n = 0; n < DRAIN_LIMIT && expected_q.size() != 0; n++) begin
      idle_cycles(1);
    end
    idle_cycles(2);                                       // room for a stray extra pulse
  endtask

  `include "gauss_score_tests.svh"

  // scoreboard, pre-edge values are stable here
  always @(posedge aclk) begin
    if (score_valid) begin
      if (expected_q.size() == 0) begin
        stop_failed($sformatf("unexpected result: score_valid high at %0t with no vector sent",
                              $time));
      end else begin
        exp_score = expected_q.pop_front();
        result_cycles.push_back(cycle_count);
        check_value("score", 64'(score), exp_score);
      end
    end
  end

  always @(posedge aclk) begin
    cycle_count <= cycle_count + 1;
    if (cycle_count >= MAX_CYCLES) begin
      stop_failed($sformatf("timeout: run did not finish within %0d cycles", MAX_CYCLES));
    end
  end

  initial begin
    aclk     = 1'b0;
    rst_n    = 1'b0;
    in_valid = 1'b0;
    clear_vector();
    test_reset_state();
    test_known_vectors();
    test_fixed_latency();
    test_streaming();
    test_gaps();
    if (expected_q.size() != 0) begin
      stop_failed($sformatf("missing results: %0d vectors never produced a score",
                            expected_q.size()));
    end else begin
      $display("test passed");
      $finish;
    end
  end

endmodule

// File: filelist.f
+incdir+sim
rtl/gauss_score_pkg.sv
rtl/feature_capture.sv
rtl/score_lane.sv
rtl/score_adder_tree.sv
rtl/gauss_score_top.sv
sim/gauss_score_asserts.sv
sim/gauss_score_tb.sv

// File: run.sh
#!/bin/sh
# Build and run the Gaussian score testbench with Verilator.
# Exit status is 0 only when the log holds the pass line.

cd "$(dirname "$0")" || exit 1

LOG=sim.log
OBJ=obj_dir
BIN=gauss_score_sim

verilator --binary --timing --assert \
  -f filelist.f \
  --top-module gauss_score_tb \
  -Mdir "$OBJ" -o "$BIN"
status=$?
if [ $status -ne 0 ]; then
  echo "build failed with status $status"
  exit 1
fi

"./$OBJ/$BIN" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if grep -q "^test passed$" "$LOG"; then
  echo "PASS"
  exit 0
else
  echo "FAIL"
  exit 1
fi
